/* files.f */
+incdir+dv
verilog/cache_cfg_pkg.sv
verilog/cache_msg_pkg.sv
verilog/intra_bank_arbiter.sv
verilog/cache_line_store.sv
verilog/cache_bank_ctrl.sv
verilog/unified_cache_bank.sv
dv/tb_unified_cache_bank.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_unified_cache_bank
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam logic [31:0] LCG_SEED = 32'h92aed478;

typedef struct packed
{
    logic [BLOCK_WIDTH-1:0]     ret_data;
    logic                       wb_expected;
    logic [ADDR_WIDTH-1:0]      wb_addr;
    logic [BLOCK_WIDTH-1:0]     wb_data;
    logic                       miss_expected;
} ref_result_t;

// Mirror of the line store and of main memory
logic                      ref_valid [NUM_SET];
logic                      ref_dirty [NUM_SET];
logic [TAG_WIDTH-1:0]      ref_tag   [NUM_SET];
logic [BLOCK_WIDTH-1:0]    ref_data  [NUM_SET];
logic [BLOCK_WIDTH-1:0]    ref_mem   [65536];

function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
endfunction

// Start value of a memory word, every address bit matters
function automatic logic [31:0] init_word(input logic [15:0] a);
    return lcg_next(LCG_SEED ^ {a, ~a});
endfunction

function automatic ref_result_t ref_access(input cache_packet_t pkt);
    ref_result_t            res;
    logic [INDEX_WIDTH-1:0] idx;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   is_write;
    res      = '0;
    idx      = pkt.address[INDEX_WIDTH-1:0];
    tag      = pkt.address[ADDR_WIDTH-1:INDEX_WIDTH];
    is_write = (pkt.opcode == OP_WRITE);
    if (ref_valid[idx] && ref_tag[idx] == tag)
    begin
        if (is_write)
        begin
            ref_data[idx]  = pkt.data;
            ref_dirty[idx] = 1'b1;
        end
    end
    else
    begin
        if (ref_valid[idx] && ref_dirty[idx])
        begin
            res.wb_expected = 1'b1;
            res.wb_addr     = {ref_tag[idx], idx};
            res.wb_data     = ref_data[idx];
            ref_mem[res.wb_addr] = ref_data[idx];
        end
        res.miss_expected = 1'b1;
        ref_valid[idx] = 1'b1;
        ref_dirty[idx] = is_write;
        ref_tag[idx]   = tag;
        ref_data[idx]  = is_write ? pkt.data : ref_mem[pkt.address];
    end
    res.ret_data = ref_data[idx];
    return res;
endfunction

`endif

/* dv/tb_unified_cache_bank.sv */
`timescale 1ns/1ps

module tb_unified_cache_bank
    import cache_cfg_pkg::*;
    import cache_msg_pkg::*;
();

localparam int NUM_REQUESTS = 16 + 16 + 3 + 8 + 300;
localparam int CYCLE_LIMIT  = 60 * NUM_REQUESTS + 20;

logic clk_in;
logic rst_n;
cache_packet_t [NUM_INPUT_PORT-1:0] request_packet;
logic [NUM_INPUT_PORT-1:0] request_valid;
logic [NUM_INPUT_PORT-1:0] request_critical;
logic [NUM_INPUT_PORT-1:0] issue_ack;
cache_packet_t fetched_request;
logic fetched_request_valid;
logic fetch_ack;
cache_packet_t miss_request;
logic miss_request_valid;
logic miss_request_critical;
logic miss_request_ack;
cache_packet_t writeback_request;
logic writeback_request_valid;
logic writeback_request_ack;
cache_packet_t return_request;
logic return_request_valid;
logic return_request_critical;
logic return_request_ack;

`include "tb_ref_model.svh"

logic [BLOCK_WIDTH-1:0] mem [65536];   // Memory seen by the responder
logic [31:0] stim_state;
logic [31:0] delay_state;
int cycle_count;
int sent_count;
int returns_seen;
int ack_cycle;
int wb_wait;
int miss_wait;
int ret_wait;
logic busy;
logic ret_prev;
logic last_was_hit;
logic wb_seen;      // Writeback observed for the current request
logic miss_seen;    // Miss observed for the current request
logic fill_taken;
logic [ADDR_WIDTH-1:0] miss_addr;
ref_result_t exp_res;
cache_packet_t exp_pkt;
logic exp_crit;
logic exp_wb_pending;
logic exp_miss_pending;
logic exp_fill_pending;

unified_cache_bank dut_i (.*);

function automatic logic [31:0] next_stim();
    stim_state = lcg_next(stim_state);
    return stim_state;
endfunction

function automatic logic [31:0] next_delay();
    delay_state = lcg_next(delay_state);
    return delay_state;
endfunction

task automatic fail_run(input string msg);
    $display("%s at time %0t", msg, $time);
    $display("TESTS FAILED");
    $fatal(1);
endtask

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
        $display("FAILED time %0t %s got %h expected %h", $time, name, got, exp);
        $display("TESTS FAILED");
        $fatal(1);
    end
endtask

task automatic check_true(input logic cond, input string msg);
    assert (cond)
    else
        fail_run(msg);
endtask

initial
begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
end

always @(posedge clk_in)
begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT)
        fail_run("Timeout, requests did not complete in time");
end

// Compares every channel transfer with the reference model
always @(posedge clk_in)
begin
    if (rst_n)
    begin
        if (|issue_ack)
        begin
            check_true(!busy, "Request acknowledged while another was in flight");
            check_true($onehot(issue_ack), "More than one issue_ack at once");
            for (int p = 0; p < NUM_INPUT_PORT; p++)
            begin
                if (issue_ack[p])
                begin
                    exp_pkt  = request_packet[p];
                    exp_crit = request_critical[p];
                end
            end
            exp_res          = ref_access(exp_pkt);
            exp_wb_pending   = exp_res.wb_expected;
            exp_miss_pending = exp_res.miss_expected;
            exp_fill_pending = 1'b0;
            last_was_hit     = !exp_res.miss_expected;
            wb_seen          = 1'b0;
            miss_seen        = 1'b0;
            ack_cycle        = cycle_count;
            busy             = 1'b1;
        end
        if (writeback_request_valid && writeback_request_ack)
        begin
            check_true(exp_wb_pending, "Unexpected writeback transfer");
            check_value("writeback_request.opcode", 64'(writeback_request.opcode),
                        64'(OP_WRITE));
            check_value("writeback_request.address", 64'(writeback_request.address),
                        64'(exp_res.wb_addr));
            check_value("writeback_request.data", 64'(writeback_request.data),
                        64'(exp_res.wb_data));
            mem[writeback_request.address] = writeback_request.data;
            exp_wb_pending = 1'b0;
            wb_seen        = 1'b1;
        end
        if (fetched_request_valid && exp_fill_pending)
            check_true(fetch_ack, "Fill was offered but not acknowledged");
        if (fetch_ack)
        begin
            check_true(exp_fill_pending, "Fill acknowledged without an outstanding miss");
            exp_fill_pending = 1'b0;
        end
        fill_taken = fetch_ack;
        if (miss_request_valid && miss_request_ack)
        begin
            check_true(!exp_wb_pending, "Miss sent before the expected writeback");
            check_true(exp_miss_pending, "Unexpected miss transfer");
            check_value("miss_request.opcode", 64'(miss_request.opcode), 64'(OP_READ));
            check_value("miss_request.address", 64'(miss_request.address),
                        64'(exp_pkt.address));
            check_value("miss_request_critical", 64'(miss_request_critical), 64'(exp_crit));
            miss_addr        = miss_request.address;
            exp_miss_pending = 1'b0;
            exp_fill_pending = 1'b1;
            miss_seen        = 1'b1;
        end
        if (return_request_valid && !ret_prev && last_was_hit && busy)
            check_value("hit return latency", 64'(cycle_count - ack_cycle), 64'd2);
        if (return_request_valid && return_request_ack)
        begin
            check_true(busy, "Return without an issued request");
            check_true(!exp_wb_pending && !exp_miss_pending && !exp_fill_pending,
                       "Return before writeback, miss or fill");
            check_value("return_request.opcode", 64'(return_request.opcode), 64'(exp_pkt.opcode));
            check_value("return_request.address", 64'(return_request.address),
                        64'(exp_pkt.address));
            check_value("return_request.data", 64'(return_request.data), 64'(exp_res.ret_data));
            check_value("return_request_critical", 64'(return_request_critical), 64'(exp_crit));
            busy         = 1'b0;
            returns_seen = returns_seen + 1;
        end
        ret_prev = return_request_valid;
    end
end

// Memory side, acknowledges after 0 to 3 cycles
always @(negedge clk_in)
begin
    if (writeback_request_ack)
        writeback_request_ack = 1'b0;
    else if (writeback_request_valid)
    begin
        if (wb_wait < 0)
            wb_wait = int'(next_delay() % 4);
        if (wb_wait == 0)
            writeback_request_ack = 1'b1;
        wb_wait = wb_wait - 1;
    end

    // Fill stays up until the bank takes it
    if (fill_taken)
        fetched_request_valid = 1'b0;

    if (miss_request_ack)
    begin
        miss_request_ack              = 1'b0;
        fetched_request.opcode        = OP_READ;
        fetched_request.address       = miss_addr;
        fetched_request.data          = mem[miss_addr];
        fetched_request_valid         = 1'b1;
    end
    else if (miss_request_valid)
    begin
        if (miss_wait < 0)
            miss_wait = int'(next_delay() % 4);
        if (miss_wait == 0)
            miss_request_ack = 1'b1;
        miss_wait = miss_wait - 1;
    end

    if (return_request_ack)
        return_request_ack = 1'b0;
    else if (return_request_valid)
    begin
        if (ret_wait < 0)
            ret_wait = int'(next_delay() % 4);
        if (ret_wait == 0)
            return_request_ack = 1'b1;
        ret_wait = ret_wait - 1;
    end
end

task automatic wait_served();
    while (returns_seen < sent_count)
        @(negedge clk_in);
endtask

task automatic send_one(input int port, input cache_opcode_e op,
                        input logic [15:0] addr, input logic [31:0] data, input logic crit);
    @(negedge clk_in);
    request_packet[port]   = '{opcode: op, address: addr, data: data};
    request_critical[port] = crit;
    request_valid[port]    = 1'b1;
    sent_count             = sent_count + 1;
    do
        @(negedge clk_in);
    while (!issue_ack[port]);
    request_valid[port] = 1'b0;
    wait_served();
endtask

task automatic send_pair(input logic crit0, input logic crit1);
    int winner;
    int first;
    @(negedge clk_in);
    for (int p = 0; p < 2; p++)
    begin
        request_packet[p] = '{opcode: OP_READ, address: 16'(next_stim() >> 8),
                              data: '0};
        request_valid[p]  = 1'b1;
    end
    request_critical = {crit1, crit0};
    sent_count       = sent_count + 2;
    winner = (crit1 && !crit0) ? 1 : 0;
    do
        @(negedge clk_in);
    while (issue_ack == '0);
    first = issue_ack[1] ? 1 : 0;
    check_value("issue_ack winner", 64'(first), 64'(winner));
    request_valid[first] = 1'b0;
    do
        @(negedge clk_in);
    while (!issue_ack[1 - first]);
    request_valid[1 - first] = 1'b0;
    wait_served();
endtask

initial
begin
    logic [31:0] r;
    logic [15:0] addr;
    stim_state            = LCG_SEED;
    delay_state           = ~LCG_SEED;
    rst_n                 = 1'b0;
    request_packet        = '0;
    request_valid         = '0;
    request_critical      = '0;
    fetched_request       = '0;
    fetched_request_valid = 1'b0;
    miss_request_ack      = 1'b0;
    writeback_request_ack = 1'b0;
    return_request_ack    = 1'b0;
    cycle_count  = 0;
    sent_count   = 0;
    returns_seen = 0;
    wb_wait      = -1;
    miss_wait    = -1;
    ret_wait     = -1;
    busy         = 1'b0;
    ret_prev     = 1'b0;
    fill_taken   = 1'b0;
    last_was_hit = 1'b0;
    wb_seen      = 1'b0;
    miss_seen    = 1'b0;
    exp_wb_pending   = 1'b0;
    exp_miss_pending = 1'b0;
    exp_fill_pending = 1'b0;
    for (int a = 0; a < 65536; a++)
    begin
        mem[a]     = init_word(16'(a));
        ref_mem[a] = init_word(16'(a));
    end
    for (int s = 0; s < NUM_SET; s++)
    begin
        ref_valid[s] = 1'b0;
        ref_dirty[s] = 1'b0;
    end
    repeat (2) @(posedge clk_in);
    @(negedge clk_in);
    rst_n = 1'b1;

    // Cold misses to every set, then hits to the same lines
    for (int s = 0; s < NUM_SET; s++)
    begin
        send_one(0, OP_READ, 16'(s + 16 * s), '0, 1'b0);
        check_true(miss_seen && !wb_seen, "Cold read did not miss without a writeback");
    end
    for (int s = 0; s < NUM_SET; s++)
    begin
        send_one(1, OP_READ, 16'(s + 16 * s), '0, 1'b0);
        check_true(!miss_seen, "Repeated read did not hit");
    end

    send_one(0, OP_WRITE, 16'h0033, 32'hcafe0123, 1'b1);
    send_one(0, OP_READ, 16'h0033, '0, 1'b0);
    send_one(1, OP_READ, 16'h0a53, '0, 1'b0);
    check_true(wb_seen, "Conflicting read did not write back the dirty victim");

    for (int m = 0; m < 4; m++)
        send_pair(m[0], m[1]);

    for (int n = 0; n < 300; n++)
    begin
        r    = next_stim();
        addr = 16'({r[21:20], r[11:8]});   // Few tags per set to force conflicts
        send_one(int'(r[0]), r[1] ? OP_WRITE : OP_READ, addr, next_stim(), r[2]);
    end

    $display("TESTS PASSED");
    $finish;
end

endmodule

/* verilog/unified_cache_bank.sv */
`timescale 1ns/1ps

module unified_cache_bank
    import cache_cfg_pkg::*;
    import cache_msg_pkg::*;
(
    input  logic                                clk_in,
    input  logic                                rst_n,

    input  cache_packet_t [NUM_INPUT_PORT-1:0]  request_packet,
    input  logic          [NUM_INPUT_PORT-1:0]  request_valid,
    input  logic          [NUM_INPUT_PORT-1:0]  request_critical,
    output logic          [NUM_INPUT_PORT-1:0]  issue_ack,

    input  cache_packet_t                       fetched_request,
    input  logic                                fetched_request_valid,
    output logic                                fetch_ack,

    output cache_packet_t                       miss_request,
    output logic                                miss_request_valid,
    output logic                                miss_request_critical,
    input  logic                                miss_request_ack,

    output cache_packet_t                       writeback_request,
    output logic                                writeback_request_valid,
    input  logic                                writeback_request_ack,

    output cache_packet_t                       return_request,
    output logic                                return_request_valid,
    output logic                                return_request_critical,
    input  logic                                return_request_ack
);

cache_packet_t             access_packet;
logic                      access_critical;
logic                      access_valid;
logic                      access_ready;
logic                      access_take;

logic [INDEX_WIDTH-1:0]    read_index;
cache_line_t               read_line;
logic                      write_en;
logic [INDEX_WIDTH-1:0]    write_index;
cache_line_t               write_line;

intra_bank_arbiter #(
    .NUM_REQUEST        (NUM_INPUT_PORT)
) arbiter_i (
    .clk_in             (clk_in),
    .rst_n              (rst_n),
    .request_packet     (request_packet),
    .request_valid      (request_valid),
    .request_critical   (request_critical),
    .issue_ack          (issue_ack),
    .access_ready       (access_ready),
    .access_take        (access_take),
    .access_packet      (access_packet),
    .access_critical    (access_critical),
    .access_valid       (access_valid)
);

cache_line_store store_i (
    .clk_in             (clk_in),
    .rst_n              (rst_n),
    .read_index         (read_index),
    .read_line          (read_line),
    .write_en           (write_en),
    .write_index        (write_index),
    .write_line         (write_line)
);

cache_bank_ctrl ctrl_i (
    .clk_in                     (clk_in),
    .rst_n                      (rst_n),
    .access_packet              (access_packet),
    .access_critical            (access_critical),
    .access_valid               (access_valid),
    .access_ready               (access_ready),
    .access_take                (access_take),
    .read_index                 (read_index),
    .read_line                  (read_line),
    .write_en                   (write_en),
    .write_index                (write_index),
    .write_line                 (write_line),
    .fetched_request            (fetched_request),
    .fetched_request_valid      (fetched_request_valid),
    .fetch_ack                  (fetch_ack),
    .writeback_request          (writeback_request),
    .writeback_request_valid    (writeback_request_valid),
    .writeback_request_ack      (writeback_request_ack),
    .miss_request               (miss_request),
    .miss_request_critical      (miss_request_critical),
    .miss_request_valid         (miss_request_valid),
    .miss_request_ack           (miss_request_ack),
    .return_request             (return_request),
    .return_request_critical    (return_request_critical),
    .return_request_valid       (return_request_valid),
    .return_request_ack         (return_request_ack)
);

endmodule

/* verilog/cache_bank_ctrl.sv */
`timescale 1ns/1ps

module cache_bank_ctrl
    import cache_cfg_pkg::*;
    import cache_msg_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    rst_n,

    input  cache_packet_t           access_packet,
    input  logic                    access_critical,
    input  logic                    access_valid,
    output logic                    access_ready,
    output logic                    access_take,

    output logic [INDEX_WIDTH-1:0]  read_index,
    input  cache_line_t             read_line,
    output logic                    write_en,
    output logic [INDEX_WIDTH-1:0]  write_index,
    output cache_line_t             write_line,

    input  cache_packet_t           fetched_request,
    input  logic                    fetched_request_valid,
    output logic                    fetch_ack,

    output cache_packet_t           writeback_request,
    output logic                    writeback_request_valid,
    input  logic                    writeback_request_ack,

    output cache_packet_t           miss_request,
    output logic                    miss_request_critical,
    output logic                    miss_request_valid,
    input  logic                    miss_request_ack,

    output cache_packet_t           return_request,
    output logic                    return_request_critical,
    output logic                    return_request_valid,
    input  logic                    return_request_ack
);

bank_state_e               state;
bank_state_e               state_next;

cache_packet_t             req;
logic                      req_critical;
logic                      req_is_write;
logic [INDEX_WIDTH-1:0]    req_index;
logic [TAG_WIDTH-1:0]      req_tag;

logic                      line_ready;     // read_line belongs to req
logic                      lookup_done;
logic                      hit;
logic                      victim_dirty;
logic [BLOCK_WIDTH-1:0]    resp_data;

assign req_is_write = (req.opcode == OP_WRITE);
assign req_index    = req.address[INDEX_WIDTH-1:0];
assign req_tag      = req.address[ADDR_WIDTH-1:INDEX_WIDTH];

assign hit          = read_line.valid && (read_line.tag == req_tag);
assign victim_dirty = read_line.valid && read_line.dirty;
assign lookup_done  = (state == LOOKUP) && line_ready;

assign access_ready = (state == IDLE);
assign access_take  = access_ready && access_valid;

// The array is only ever addressed with the held request
assign read_index   = req_index;
assign write_index  = req_index;

assign fetch_ack    = (state == FILL) && fetched_request_valid;

// Write hit and fill share one line format
assign write_en         = (lookup_done && hit && req_is_write) || fetch_ack;
assign write_line.valid = 1'b1;
assign write_line.dirty = req_is_write;
assign write_line.tag   = req_tag;
assign write_line.data  = req_is_write ? req.data : fetched_request.data;

// Array is not written before FILL, so the victim stays on read_line
assign writeback_request.opcode  = OP_WRITE;
assign writeback_request.address = {read_line.tag, req_index};
assign writeback_request.data    = read_line.data;
assign writeback_request_valid   = (state == WRITEBACK);

assign miss_request.opcode   = OP_READ;
assign miss_request.address  = req.address;
assign miss_request.data     = '0;
assign miss_request_critical = req_critical;
assign miss_request_valid    = (state == MISS);

assign return_request.opcode   = req.opcode;
assign return_request.address  = req.address;
assign return_request.data     = resp_data;
assign return_request_critical = req_critical;
assign return_request_valid    = (state == RESPOND);

always_comb
begin
    state_next = state;
    case (state)
        IDLE:
        begin
            if (access_take)
                state_next = LOOKUP;
        end
        LOOKUP:
        begin
            // First cycle only reads the array
            if (line_ready)
            begin
                if (hit)
                    state_next = RESPOND;
                else if (victim_dirty)
                    state_next = WRITEBACK;
                else
                    state_next = MISS;
            end
        end
        WRITEBACK:
        begin
            if (writeback_request_ack)
                state_next = MISS;
        end
        MISS:
        begin
            if (miss_request_ack)
                state_next = FILL;
        end
        FILL:
        begin
            if (fetched_request_valid)
                state_next = RESPOND;
        end
        RESPOND:
        begin
            if (return_request_ack)
                state_next = IDLE;
        end
        default: state_next = IDLE;
    endcase
end

always_ff @(posedge clk_in)
begin
    if (!rst_n)
    begin
        state      <= IDLE;
        line_ready <= 1'b0;
    end
    else
    begin
        state      <= state_next;
        line_ready <= (state == LOOKUP) && !line_ready;
    end
end

always_ff @(posedge clk_in)
begin
    if (access_take)
    begin
        req          <= access_packet;
        req_critical <= access_critical;
    end

    if (lookup_done && hit)
        resp_data <= req_is_write ? req.data : read_line.data;
    else if (fetch_ack)
        resp_data <= write_line.data;   // Line as installed
end

endmodule

/* verilog/cache_line_store.sv */
`timescale 1ns/1ps

module cache_line_store
    import cache_cfg_pkg::*;
    import cache_msg_pkg::*;
(
    input  logic                    clk_in,
    input  logic                    rst_n,

    input  logic [INDEX_WIDTH-1:0]  read_index,
    output cache_line_t             read_line,

    input  logic                    write_en,
    input  logic [INDEX_WIDTH-1:0]  write_index,
    input  cache_line_t             write_line
);

cache_line_t lines [NUM_SET];

// Only the valid bits see reset
always_ff @(posedge clk_in)
begin
    if (!rst_n)
    begin
        for (int i = 0; i < NUM_SET; i++)
        begin
            lines[i].valid <= 1'b0;
        end
    end
    else if (write_en)
    begin
        lines[write_index] <= write_line;   // Whole line at once
    end
end

// Registered read, old contents on a same-cycle write
always_ff @(posedge clk_in)
begin
    read_line <= lines[read_index];
end

endmodule

/* verilog/intra_bank_arbiter.sv */
`timescale 1ns/1ps

module intra_bank_arbiter
    import cache_msg_pkg::*;
#(
    parameter int NUM_REQUEST = 2
)
(
    input  logic                            clk_in,
    input  logic                            rst_n,

    input  cache_packet_t [NUM_REQUEST-1:0] request_packet,
    input  logic          [NUM_REQUEST-1:0] request_valid,
    input  logic          [NUM_REQUEST-1:0] request_critical,
    output logic          [NUM_REQUEST-1:0] issue_ack,

    input  logic                            access_ready,
    input  logic                            access_take,
    output cache_packet_t                   access_packet,
    output logic                            access_critical,
    output logic                            access_valid
);

logic [NUM_REQUEST-1:0] candidate;
logic [NUM_REQUEST-1:0] grant;

// Critical requests shadow the others, then lowest port wins
always_comb
begin
    candidate = request_valid & request_critical;
    if (candidate == '0)
        candidate = request_valid;

    grant           = '0;
    access_packet   = '0;
    access_critical = 1'b0;
    for (int i = NUM_REQUEST - 1; i >= 0; i--)
    begin
        if (candidate[i])
        begin
            grant           = '0;
            grant[i]        = 1'b1;
            access_packet   = request_packet[i];
            access_critical = request_critical[i];
        end
    end
end

assign access_valid = (|request_valid) & access_ready;

// Requester sees the ack one cycle after the controller takes the request
always_ff @(posedge clk_in)
begin
    if (!rst_n)
        issue_ack <= '0;
    else
        issue_ack <= access_take ? grant : '0;
end

endmodule

/* verilog/cache_msg_pkg.sv */
package cache_msg_pkg;

    import cache_cfg_pkg::*;

    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_opcode_e;

    // Same layout on every channel: requests, writeback, miss, fill and return
    typedef struct packed
    {
        cache_opcode_e              opcode;
        logic [ADDR_WIDTH-1:0]      address;
        logic [BLOCK_WIDTH-1:0]     data;
    } cache_packet_t;

    typedef struct packed
    {
        logic                       valid;
        logic                       dirty;
        logic [TAG_WIDTH-1:0]       tag;
        logic [BLOCK_WIDTH-1:0]     data;
    } cache_line_t;

    // Bank controller FSM
    typedef enum logic [2:0]
    {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WRITEBACK = 3'd2,
        MISS      = 3'd3,
        FILL      = 3'd4,
        RESPOND   = 3'd5
    } bank_state_e;

endpackage

/* verilog/cache_cfg_pkg.sv */
package cache_cfg_pkg;

    // Requesters sharing this bank
    localparam int NUM_INPUT_PORT = 2;

    // Addresses count whole blocks, there is no byte offset
    localparam int ADDR_WIDTH     = 16;
    localparam int BLOCK_WIDTH    = 32;   // One word per block

    // Direct mapped, one line per set
    localparam int NUM_SET        = 16;

    // Index sits in the low address bits, tag above it
    localparam int INDEX_WIDTH    = $clog2(NUM_SET);
    localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH;

endpackage
